//--- build.f
+incdir+source
source/ulpb_bus_pkg.sv
source/ulpb_msg_pkg.sv
source/msg_if.sv
source/bus_ctrl.sv
source/bus_tx_node.sv
source/bus_rx_node.sv
source/msg_fifo.sv
source/ulpb_top.sv
tests/tb_clock.sv
tests/ulpb_asserts.sv
tests/ulpb_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ulpb_tb -f build.f -o Vulpb_tb

./obj_dir/Vulpb_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

//--- source/bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ulpb_defs.svh"

module bus_ctrl (
	input logic CLK,
	input logic RESET,
	input logic din,
	output logic dout,
	output logic bus_clk
);

	localparam int CNT_W = $clog2(`ULPB_START_CYCLES);

	ulpb_bus_pkg::ctrl_state_e state, next_state;
	ulpb_bus_pkg::ctrl_bit_e cbit, next_cbit;
	logic [CNT_W-1:0] start_cnt, next_start_cnt;
	logic next_bus_clk;
	logic din_q;
	logic interjection;

	// Line is released only while bits are on the ring
	assign dout = (state == ulpb_bus_pkg::ctrl_data || state == ulpb_bus_pkg::ctrl_control)
		? din : 1'b1;

	// Data moving while the bus clock is high
	assign interjection = bus_clk && (din != din_q);

	always_comb
	begin
		next_state = state;
		next_cbit = cbit;
		next_start_cnt = start_cnt;
		next_bus_clk = bus_clk;
		case (state)
			ulpb_bus_pkg::ctrl_idle:
			begin
				next_bus_clk = 1'b1;
				next_start_cnt = CNT_W'(`ULPB_START_CYCLES - 1);
				if (!din)
					next_state = ulpb_bus_pkg::ctrl_wait_start;
			end
			ulpb_bus_pkg::ctrl_wait_start:
			begin
				if (start_cnt != '0)
					next_start_cnt = start_cnt - 1'b1;
				else
				begin
					next_state = ulpb_bus_pkg::ctrl_arbitrate;
					next_bus_clk = 1'b0;
				end
			end
			ulpb_bus_pkg::ctrl_arbitrate:
			begin
				next_bus_clk = ~bus_clk;
				if (bus_clk)
					next_state = ulpb_bus_pkg::ctrl_data;
			end
			ulpb_bus_pkg::ctrl_data:
			begin
				next_bus_clk = ~bus_clk;
				if (interjection)
				begin
					next_state = ulpb_bus_pkg::ctrl_control;
					next_cbit = ulpb_bus_pkg::bit_complete;
				end
			end
			ulpb_bus_pkg::ctrl_control:
			begin
				next_bus_clk = ~bus_clk;
				if (bus_clk)
				begin
					if (cbit == ulpb_bus_pkg::bit_ack)
						next_state = ulpb_bus_pkg::ctrl_back_to_idle;
					else
						next_cbit = ulpb_bus_pkg::bit_ack;
				end
			end
			// One more rising edge brings the nodes home
			ulpb_bus_pkg::ctrl_back_to_idle:
			begin
				next_bus_clk = 1'b1;
				next_state = ulpb_bus_pkg::ctrl_idle;
			end
			default:
			begin
				next_state = ulpb_bus_pkg::ctrl_idle;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ulpb_bus_pkg::ctrl_idle;
			cbit <= ulpb_bus_pkg::bit_complete;
			start_cnt <= CNT_W'(`ULPB_START_CYCLES - 1);
			bus_clk <= 1'b1;
			din_q <= 1'b1;
		end
		else
		begin
			state <= next_state;
			cbit <= next_cbit;
			start_cnt <= next_start_cnt;
			bus_clk <= next_bus_clk;
			din_q <= din;
		end
	end

endmodule

`default_nettype wire

//--- source/bus_rx_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "ulpb_defs.svh"

module bus_rx_node (
	input logic CLK,
	input logic RESET,
	input logic din,
	output logic dout,
	input logic bus_clk,
	msg_if.rx wr
);

	localparam int MSG_BITS = `ULPB_ADDR_BITS + `ULPB_DATA_BITS;

	ulpb_bus_pkg::node_state_e state;
	ulpb_bus_pkg::ctrl_bit_e cbit;
	logic [MSG_BITS-1:0] sr;
	logic [$clog2(MSG_BITS+1)-1:0] cnt;
	logic din_q;
	logic ack_en;

	// Pull low only in the acknowledge bit
	assign dout = (state == ulpb_bus_pkg::node_control && cbit == ulpb_bus_pkg::bit_ack
		&& ack_en) ? 1'b0 : din;

	assign wr.msg = ulpb_msg_pkg::msg_t'(sr);

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ulpb_bus_pkg::node_idle;
			cbit <= ulpb_bus_pkg::bit_complete;
			cnt <= '0;
			din_q <= 1'b1;
			ack_en <= 1'b0;
			wr.valid <= 1'b0;
		end
		else
		begin
			din_q <= din;
			wr.valid <= 1'b0;
			case (state)
				// First low half is the arbitration bit
				ulpb_bus_pkg::node_idle:
				begin
					if (!bus_clk)
						state <= ulpb_bus_pkg::node_wait_arb;
				end
				ulpb_bus_pkg::node_wait_arb:
				begin
					if (bus_clk)
					begin
						state <= ulpb_bus_pkg::node_send;
						cnt <= '0;
					end
				end
				// Bits on the wire
				ulpb_bus_pkg::node_send:
				begin
					if (bus_clk && din != din_q)
					begin
						state <= ulpb_bus_pkg::node_control;
						cbit <= ulpb_bus_pkg::bit_complete;
						ack_en <= (sr[MSG_BITS-1 -: `ULPB_ADDR_BITS] == `ULPB_RX_ADDRESS)
							&& !wr.full;
					end
					else if (!bus_clk && cnt != MSG_BITS)
						cnt <= cnt + 1'b1;
				end
				ulpb_bus_pkg::node_control:
				begin
					if (bus_clk)
					begin
						if (cbit == ulpb_bus_pkg::bit_ack)
							state <= ulpb_bus_pkg::node_done;
						else
						begin
							cbit <= ulpb_bus_pkg::bit_ack;
							wr.valid <= ack_en;
						end
					end
				end
				ulpb_bus_pkg::node_done:
				begin
					if (!bus_clk)
						state <= ulpb_bus_pkg::node_idle;
				end
				default:
				begin
					state <= ulpb_bus_pkg::node_idle;
				end
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == ulpb_bus_pkg::node_send && !bus_clk && cnt != MSG_BITS)
			sr <= {sr[MSG_BITS-2:0], din};
	end

endmodule

`default_nettype wire

//--- source/bus_tx_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "ulpb_defs.svh"

module bus_tx_node (
	input logic CLK,
	input logic RESET,
	input logic din,
	output logic dout,
	input logic bus_clk,
	input logic tx_req,
	input ulpb_msg_pkg::addr_t tx_addr,
	input ulpb_msg_pkg::data_t tx_data,
	output logic tx_ack,
	output logic tx_acked
);

	localparam int MSG_BITS = `ULPB_ADDR_BITS + `ULPB_DATA_BITS;

	ulpb_bus_pkg::node_state_e state;
	ulpb_bus_pkg::ctrl_bit_e cbit;
	logic [MSG_BITS-1:0] sr;
	logic [$clog2(MSG_BITS)-1:0] cnt;
	logic tog;

	always_comb
	begin
		case (state)
			ulpb_bus_pkg::node_request,
			ulpb_bus_pkg::node_wait_arb: dout = 1'b0;
			ulpb_bus_pkg::node_send: dout = sr[MSG_BITS-1];
			ulpb_bus_pkg::node_interject: dout = sr[MSG_BITS-1] ^ tog;
			ulpb_bus_pkg::node_control,
			ulpb_bus_pkg::node_done: dout = 1'b1;
			default: dout = din;
		endcase
	end

	assign tx_ack = (state == ulpb_bus_pkg::node_done);

	// bus_clk high means the next edge is a falling one, low means rising
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ulpb_bus_pkg::node_idle;
			cbit <= ulpb_bus_pkg::bit_complete;
			cnt <= '0;
			tog <= 1'b0;
			tx_acked <= 1'b0;
		end
		else
		begin
			case (state)
				ulpb_bus_pkg::node_idle:
				begin
					if (tx_req)
					begin
						state <= ulpb_bus_pkg::node_request;
						cnt <= '0;
					end
				end
				ulpb_bus_pkg::node_request:
				begin
					if (!bus_clk)
						state <= ulpb_bus_pkg::node_wait_arb;
				end
				ulpb_bus_pkg::node_wait_arb:
				begin
					if (bus_clk)
						state <= ulpb_bus_pkg::node_send;
				end
				ulpb_bus_pkg::node_send:
				begin
					if (bus_clk)
					begin
						if (cnt == MSG_BITS - 1)
						begin
							state <= ulpb_bus_pkg::node_interject;
							tog <= 1'b0;
						end
						else
							cnt <= cnt + 1'b1;
					end
				end
				// Flip the line at the rising edge so it moves within the high half
				ulpb_bus_pkg::node_interject:
				begin
					if (!bus_clk)
						tog <= 1'b1;
					else if (tog)
					begin
						state <= ulpb_bus_pkg::node_control;
						cbit <= ulpb_bus_pkg::bit_complete;
					end
				end
				ulpb_bus_pkg::node_control:
				begin
					if (bus_clk)
						cbit <= ulpb_bus_pkg::bit_ack;
					else if (cbit == ulpb_bus_pkg::bit_ack)
					begin
						// Receiver pulls low to acknowledge
						tx_acked <= ~din;
						state <= ulpb_bus_pkg::node_done;
					end
				end
				ulpb_bus_pkg::node_done:
				begin
					if (!tx_req)
						state <= ulpb_bus_pkg::node_idle;
				end
				default:
				begin
					state <= ulpb_bus_pkg::node_idle;
				end
			endcase
		end
	end

	// Message shift register
	always_ff @(posedge CLK)
	begin
		if (state == ulpb_bus_pkg::node_idle && tx_req)
			sr <= {tx_addr, tx_data};
		else if (state == ulpb_bus_pkg::node_send && bus_clk && cnt != MSG_BITS - 1)
			sr <= {sr[MSG_BITS-2:0], 1'b0};
	end

endmodule

`default_nettype wire

//--- source/msg_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ulpb_defs.svh"

module msg_fifo #(
	parameter int DEPTH = `ULPB_FIFO_DEPTH
) (
	input logic CLK,
	input logic RESET,
	msg_if.fifo wr,
	output logic rx_req,
	input logic rx_ack,
	output ulpb_msg_pkg::addr_t rx_addr,
	output ulpb_msg_pkg::data_t rx_data
);

	localparam int PTR_W = $clog2(DEPTH);

	ulpb_msg_pkg::msg_t mem [DEPTH];
	logic [PTR_W-1:0] wptr, rptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic ack_q;
	logic push, pop;

	assign wr.full = (count == DEPTH);
	assign push = wr.valid && !wr.full;
	// Pop on the rising edge of the host acknowledge
	assign pop = rx_req && rx_ack && !ack_q;

	assign rx_addr = mem[rptr].addr;
	assign rx_data = mem[rptr].data;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
			ack_q <= 1'b0;
			rx_req <= 1'b0;
		end
		else
		begin
			ack_q <= rx_ack;
			if (push)
				wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (pop)
			begin
				rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
				rx_req <= 1'b0;
			end
			else if (!rx_req && !rx_ack && !ack_q && count != '0)
				rx_req <= 1'b1;
			count <= count + push - pop;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wptr] <= wr.msg;
	end

endmodule

`default_nettype wire

//--- source/msg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface msg_if;

	logic valid;
	ulpb_msg_pkg::msg_t msg;
	logic full;

	// Receiving node side
	modport rx (output valid, output msg, input full);

	// FIFO side
	modport fifo (input valid, input msg, output full);

endinterface

`default_nettype wire

//--- source/ulpb_bus_pkg.sv
`default_nettype none

package ulpb_bus_pkg;

	typedef enum logic [2:0] {
		ctrl_idle,
		ctrl_wait_start,
		ctrl_arbitrate,
		ctrl_data,
		ctrl_control,
		ctrl_back_to_idle
	} ctrl_state_e;

	// Shared by the transmitting and the receiving node
	typedef enum logic [2:0] {
		node_idle,
		node_request,
		node_wait_arb,
		node_send,
		node_interject,
		node_control,
		node_done
	} node_state_e;

	typedef enum logic {
		bit_complete = 1'b0,
		bit_ack = 1'b1
	} ctrl_bit_e;

endpackage

`default_nettype wire

//--- source/ulpb_defs.svh
`ifndef ULPB_DEFS_SVH
`define ULPB_DEFS_SVH

// Idle to first bus clock edge, in CLK cycles
`define ULPB_START_CYCLES 12

// Message field widths
`define ULPB_ADDR_BITS 4
`define ULPB_DATA_BITS 8

// Address the receiving node answers to
`define ULPB_RX_ADDRESS 4'h5

// Entries in the receive message FIFO
`define ULPB_FIFO_DEPTH 4

`endif

//--- source/ulpb_msg_pkg.sv
`default_nettype none

`include "ulpb_defs.svh"

package ulpb_msg_pkg;

	typedef logic [`ULPB_ADDR_BITS-1:0] addr_t;
	typedef logic [`ULPB_DATA_BITS-1:0] data_t;

	// Address sits in the upper bits, as sent on the wire
	typedef struct packed {
		addr_t addr;
		data_t data;
	} msg_t;

endpackage

`default_nettype wire

//--- source/ulpb_top.sv
`timescale 1ns/1ps
`default_nettype none

module ulpb_top (
	input logic CLK,
	input logic RESET,
	input logic tx_req,
	input ulpb_msg_pkg::addr_t tx_addr,
	input ulpb_msg_pkg::data_t tx_data,
	output logic tx_ack,
	output logic tx_acked,
	output logic rx_req,
	input logic rx_ack,
	output ulpb_msg_pkg::addr_t rx_addr,
	output ulpb_msg_pkg::data_t rx_data,
	output logic bus_clk
);

	// Data ring segments
	logic ctrl_to_tx;
	logic tx_to_rx;
	logic rx_to_ctrl;

	msg_if u_msg_if ();

	bus_ctrl u_ctrl (
		.CLK(CLK),
		.RESET(RESET),
		.din(rx_to_ctrl),
		.dout(ctrl_to_tx),
		.bus_clk(bus_clk)
	);

	bus_tx_node u_tx (
		.CLK(CLK),
		.RESET(RESET),
		.din(ctrl_to_tx),
		.dout(tx_to_rx),
		.bus_clk(bus_clk),
		.tx_req(tx_req),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_ack(tx_ack),
		.tx_acked(tx_acked)
	);

	bus_rx_node u_rx (
		.CLK(CLK),
		.RESET(RESET),
		.din(tx_to_rx),
		.dout(rx_to_ctrl),
		.bus_clk(bus_clk),
		.wr(u_msg_if.rx)
	);

	msg_fifo u_fifo (
		.CLK(CLK),
		.RESET(RESET),
		.wr(u_msg_if.fifo),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_addr(rx_addr),
		.rx_data(rx_data)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic CLK,
	output logic RESET
);

	// 40 ns period
	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	initial
	begin
		RESET = 1'b0;
		repeat (4) @(posedge CLK);
		#1;
		RESET = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/ulpb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ulpb_asserts (
	input logic CLK,
	input logic RESET,
	input logic tx_req,
	input logic tx_ack,
	input logic rx_req,
	input ulpb_msg_pkg::addr_t rx_addr,
	input ulpb_msg_pkg::data_t rx_data,
	input logic bus_clk,
	input ulpb_bus_pkg::ctrl_state_e ctrl_state
);

	localparam int BUSY_LIMIT = 200;

	logic [7:0] busy_cnt;

	// Failed assertions so far
	int fail_count = 0;

	// Cycles spent out of idle, saturating
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			busy_cnt <= '0;
		else if (ctrl_state == ulpb_bus_pkg::ctrl_idle)
			busy_cnt <= '0;
		else if (busy_cnt != '1)
			busy_cnt <= busy_cnt + 1'b1;
	end

	tx_ack_needs_req: assert property (@(posedge CLK) disable iff (!RESET)
		$rose(tx_ack) |-> $past(tx_req))
		else
		begin
			fail_count++;
			$error("tx_ack rose while tx_req was low");
		end

	rx_head_stable: assert property (@(posedge CLK) disable iff (!RESET)
		(rx_req && $past(rx_req)) |-> ($stable(rx_addr) && $stable(rx_data)))
		else
		begin
			fail_count++;
			$error("rx_addr or rx_data moved while rx_req was high");
		end

	idle_clk_high: assert property (@(posedge CLK) disable iff (!RESET)
		(ctrl_state == ulpb_bus_pkg::ctrl_idle) |-> bus_clk)
		else
		begin
			fail_count++;
			$error("bus_clk low while the controller is idle");
		end

	busy_bounded: assert property (@(posedge CLK) disable iff (!RESET)
		busy_cnt < BUSY_LIMIT)
		else
		begin
			fail_count++;
			$error("controller stuck out of idle");
		end

endmodule

bind ulpb_top ulpb_asserts u_asserts (
	.CLK(CLK),
	.RESET(RESET),
	.tx_req(tx_req),
	.tx_ack(tx_ack),
	.rx_req(rx_req),
	.rx_addr(rx_addr),
	.rx_data(rx_data),
	.bus_clk(bus_clk),
	.ctrl_state(u_ctrl.state)
);

`default_nettype wire

//--- tests/ulpb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ulpb_defs.svh"

module ulpb_tb;

	localparam int WAIT_LIMIT = 400;
	localparam int NUM_STIM = 14;

	typedef struct packed {
		ulpb_msg_pkg::addr_t addr;
		logic drain;
		logic exp_acked;
		logic exp_store;
	} stim_t;

	logic CLK;
	logic RESET;
	logic tx_req;
	ulpb_msg_pkg::addr_t tx_addr;
	ulpb_msg_pkg::data_t tx_data;
	logic tx_ack;
	logic tx_acked;
	logic rx_req;
	logic rx_ack;
	ulpb_msg_pkg::addr_t rx_addr;
	ulpb_msg_pkg::data_t rx_data;
	logic bus_clk;

	stim_t stim [NUM_STIM];
	ulpb_msg_pkg::msg_t pending [$];
	ulpb_msg_pkg::msg_t msg;
	ulpb_msg_pkg::data_t data;
	logic [15:0] lfsr;
	logic model_store;
	string name;
	int idx;

	tb_clock u_clock (
		.CLK(CLK),
		.RESET(RESET)
	);

	ulpb_top UUT (
		.CLK(CLK),
		.RESET(RESET),
		.tx_req(tx_req),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_ack(tx_ack),
		.tx_acked(tx_acked),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.bus_clk(bus_clk)
	);

	task automatic stop_run();
	begin
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error");
	end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
	begin
		if (actual !== expected)
		begin
			$display("Error: %s expected %b actual %b", what, expected, actual);
			stop_run();
		end
	end
	endtask

	task automatic check_addr(input string what, input ulpb_msg_pkg::addr_t expected,
		input ulpb_msg_pkg::addr_t actual);
	begin
		if (actual !== expected)
		begin
			$display("Error: %s expected %h actual %h", what, expected, actual);
			stop_run();
		end
	end
	endtask

	task automatic check_data(input string what, input ulpb_msg_pkg::data_t expected,
		input ulpb_msg_pkg::data_t actual);
	begin
		if (actual !== expected)
		begin
			$display("Error: %s expected %h actual %h", what, expected, actual);
			stop_run();
		end
	end
	endtask

	// Taps for x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic fb;
	begin
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		lfsr_step = {state[14:0], fb};
	end
	endfunction

	task automatic next_data(output ulpb_msg_pkg::data_t value);
		int i;
	begin
		value = '0;
		for (i = 0; i < `ULPB_DATA_BITS; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = {value[`ULPB_DATA_BITS-2:0], lfsr[0]};
		end
	end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step();
	begin
		@(posedge CLK);
		#1;
	end
	endtask

	task automatic wait_reset_release();
		int n;
	begin
		n = 0;
		while (RESET !== 1'b1 && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (RESET !== 1'b1)
		begin
			$display("Reset was never released");
			stop_run();
		end
		step();
	end
	endtask

	task automatic wait_tx_ack(input logic level);
		int n;
	begin
		n = 0;
		while (tx_ack !== level && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (tx_ack !== level)
		begin
			$display("Timed out waiting for tx_ack to become %b", level);
			stop_run();
		end
	end
	endtask

	task automatic wait_rx_req(input logic level);
		int n;
	begin
		n = 0;
		while (rx_req !== level && n < WAIT_LIMIT)
		begin
			step();
			n++;
		end
		if (rx_req !== level)
		begin
			$display("Timed out waiting for rx_req to become %b", level);
			stop_run();
		end
	end
	endtask

	task automatic send_message(input ulpb_msg_pkg::addr_t addr,
		input ulpb_msg_pkg::data_t value, input logic exp_acked, input string what);
	begin
		tx_addr = addr;
		tx_data = value;
		tx_req = 1'b1;
		wait_tx_ack(1'b1);
		check_bit({what, " tx_acked"}, exp_acked, tx_acked);
		tx_req = 1'b0;
		wait_tx_ack(1'b0);
	end
	endtask

	task automatic drain_one(input string what);
		ulpb_msg_pkg::msg_t head;
	begin
		head = pending.pop_front();
		wait_rx_req(1'b1);
		check_addr({what, " rx_addr"}, head.addr, rx_addr);
		check_data({what, " rx_data"}, head.data, rx_data);
		rx_ack = 1'b1;
		wait_rx_req(1'b0);
		rx_ack = 1'b0;
		step();
	end
	endtask

	task automatic drain_all(input string what);
	begin
		while (pending.size() != 0)
			drain_one(what);
		// Nothing left, so no new request
		repeat (3) step();
		check_bit({what, " rx_req after drain"}, 1'b0, rx_req);
	end
	endtask

	// addr, drain afterwards, expected tx_acked, expected stored
	task automatic load_table();
	begin
		stim[0] = '{`ULPB_RX_ADDRESS, 1'b1, 1'b1, 1'b1};
		stim[1] = '{4'h3, 1'b0, 1'b0, 1'b0};
		stim[2] = '{`ULPB_RX_ADDRESS, 1'b1, 1'b1, 1'b1};
		// Fill the FIFO, then one too many
		stim[3] = '{`ULPB_RX_ADDRESS, 1'b0, 1'b1, 1'b1};
		stim[4] = '{`ULPB_RX_ADDRESS, 1'b0, 1'b1, 1'b1};
		stim[5] = '{`ULPB_RX_ADDRESS, 1'b0, 1'b1, 1'b1};
		stim[6] = '{`ULPB_RX_ADDRESS, 1'b0, 1'b1, 1'b1};
		stim[7] = '{`ULPB_RX_ADDRESS, 1'b1, 1'b0, 1'b0};
		// Interleaved
		stim[8] = '{`ULPB_RX_ADDRESS, 1'b0, 1'b1, 1'b1};
		stim[9] = '{`ULPB_RX_ADDRESS, 1'b1, 1'b1, 1'b1};
		stim[10] = '{4'hA, 1'b0, 1'b0, 1'b0};
		stim[11] = '{`ULPB_RX_ADDRESS, 1'b1, 1'b1, 1'b1};
		stim[12] = '{`ULPB_RX_ADDRESS, 1'b0, 1'b1, 1'b1};
		stim[13] = '{`ULPB_RX_ADDRESS, 1'b1, 1'b1, 1'b1};
	end
	endtask

	// Protocol checker failures end the run as well
	always @(negedge CLK)
	begin
		if (UUT.u_asserts.fail_count != 0)
		begin
			$display("The bound protocol checker reported an assertion failure");
			stop_run();
		end
	end

	initial
	begin
		tx_req = 1'b0;
		tx_addr = '0;
		tx_data = '0;
		rx_ack = 1'b0;
		lfsr = 16'd75;
		load_table();
		wait_reset_release();

		check_bit("reset tx_ack", 1'b0, tx_ack);
		check_bit("reset rx_req", 1'b0, rx_req);
		check_bit("reset bus_clk", 1'b1, bus_clk);

		for (idx = 0; idx < NUM_STIM; idx++)
		begin
			name = $sformatf("msg %0d", idx);
			next_data(data);
			model_store = (stim[idx].addr == `ULPB_RX_ADDRESS)
				&& (pending.size() < `ULPB_FIFO_DEPTH);
			check_bit({name, " model store"}, stim[idx].exp_store, model_store);
			send_message(stim[idx].addr, data, stim[idx].exp_acked, name);
			if (model_store)
			begin
				msg.addr = stim[idx].addr;
				msg.data = data;
				pending.push_back(msg);
			end
			if (stim[idx].drain)
				drain_all(name);
		end

		if (UUT.u_asserts.fail_count == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("The bound protocol checker reported an assertion failure");
			stop_run();
		end
	end

endmodule

`default_nettype wire
